// ==== src/cell_pkg.sv ====
`default_nettype none

package cell_pkg;

  // Memory geometry
  localparam int addr_width = 10;
  localparam int noun_width = addr_width;
  localparam int tag_width  = 8;
  localparam int word_width = tag_width + 2 * noun_width;
  localparam int mem_depth  = 1024;

  // All ones marks the end of the parent chain
  localparam logic [addr_width-1:0] nil_addr = '1;

  // Node kind in tag bits 1..0
  // Bit 1 set means the head is a cell, bit 0 set means the tail is a cell
  typedef enum logic [1:0] {
    atom_atom = 2'b00,
    atom_cell = 2'b01,
    cell_atom = 2'b10,
    cell_cell = 2'b11
  } node_kind_e;

  // Visited marks, only set while the walker is below that side
  localparam int hed_visited_bit = 3;
  localparam int tel_visited_bit = 2;

  // One memory word
  typedef struct packed {
    logic [tag_width-1:0]  tag;
    logic [noun_width-1:0] hed;
    logic [noun_width-1:0] tel;
  } cell_word_t;

endpackage

`default_nettype wire

// ==== src/walk_pkg.sv ====
`default_nettype none

package walk_pkg;

  import cell_pkg::*;

  // Memory operation carried with each request
  typedef enum logic {
    get_contents = 1'b0,
    set_contents = 1'b1
  } mem_op_e;

  // Request held stable by the requester until ready
  typedef struct packed {
    logic                  valid;
    mem_op_e               op;
    logic [addr_width-1:0] addr;
    cell_word_t            wdata;
  } mem_req_t;

  // Engine sequencer states
  typedef enum logic [1:0] {
    func_read     = 2'b00,
    func_write    = 2'b01,
    func_traverse = 2'b10
  } walk_func_e;

  // Per-node decision of the pointer reversal
  typedef enum logic [1:0] {
    act_push   = 2'b00,
    act_pop    = 2'b01,
    act_switch = 2'b10,
    act_leaf   = 2'b11
  } rev_action_e;

endpackage

`default_nettype wire

// ==== src/cell_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module cell_store
  import cell_pkg::*;
  import walk_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire mem_req_t   walk_req,
  output cell_word_t      walk_rdata,
  output logic            walk_ready,
  input  wire mem_req_t   host_req,
  output cell_word_t      host_rdata,
  output logic            host_ready
);

  cell_word_t mem [mem_depth];
  cell_word_t rdata_q;
  mem_req_t   req;
  logic       walk_accept;
  logic       host_accept;

  // A request is taken once, the ready cycle blocks a second accept
  assign walk_accept = walk_req.valid && !walk_ready;
  // Walker wins the single port
  assign host_accept = host_req.valid && !host_ready && !walk_accept;
  assign req         = walk_accept ? walk_req : host_req;

  always_ff @(posedge clk) begin
    if (walk_accept || host_accept) begin
      if (req.op == set_contents) begin
        mem[req.addr] <= req.wdata;
      end
      rdata_q <= mem[req.addr];
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      walk_ready <= 1'b0;
      host_ready <= 1'b0;
    end else begin
      walk_ready <= walk_accept;
      host_ready <= host_accept;
    end
  end

  assign walk_rdata = rdata_q;
  assign host_rdata = rdata_q;

  // Walker must hold its request until answered
  a_walk_hold: assert property (@(posedge clk) disable iff (!rst)
    walk_req.valid && !walk_ready |=> walk_req.valid);

  // Host only talks to memory while the walker is idle
  a_no_collision: assert property (@(posedge clk) disable iff (!rst)
    !(walk_req.valid && host_req.valid));

endmodule

`default_nettype wire

// ==== src/pointer_reversal.sv ====
`timescale 1ns/1ps
`default_nettype none

module pointer_reversal
  import cell_pkg::*;
  import walk_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  start,
  input  wire logic [addr_width-1:0] start_addr,
  input  wire logic                  step,
  input  wire cell_word_t            node,
  output rev_action_e                action,
  output cell_word_t                 node_next,
  output logic [addr_width-1:0]      next_addr
);

  logic [addr_width-1:0] back_q;
  logic [addr_width-1:0] cur_q;
  logic                  tel_pend_q;
  logic                  use_tel;
  logic                  hed_vis;
  logic                  tel_vis;
  logic [addr_width-1:0] field;

  assign hed_vis = node.tag[hed_visited_bit];
  assign tel_vis = node.tag[tel_visited_bit];
  // Field that is followed on a push or restored on a pop
  assign field   = use_tel ? node.tel : node.hed;

  // Decide the action from kind and visited marks
  always_comb begin
    action  = act_leaf;
    use_tel = 1'b0;
    if (tel_pend_q) begin
      // Second half of a switch
      action  = act_push;
      use_tel = 1'b1;
    end else begin
      case (node_kind_e'(node.tag[1:0]))
        cell_cell: begin
          if (!hed_vis) begin
            action = act_push;
          end else if (!tel_vis) begin
            action = act_switch;
          end else begin
            action  = act_pop;
            use_tel = 1'b1;
          end
        end
        cell_atom: action = hed_vis ? act_pop : act_push;
        atom_cell: begin
          action  = tel_vis ? act_pop : act_push;
          use_tel = 1'b1;
        end
        default: action = act_leaf;
      endcase
    end
  end

  // Rewritten node and the next address to read
  always_comb begin
    node_next = node;
    next_addr = back_q;
    case (action)
      act_push: begin
        node_next.tag[use_tel ? tel_visited_bit : hed_visited_bit] = 1'b1;
        if (use_tel) node_next.tel = back_q;
        else         node_next.hed = back_q;
        next_addr = field;
      end
      act_switch: begin
        node_next.hed = cur_q;
        next_addr     = node.tel;
      end
      act_pop: begin
        node_next.tag[hed_visited_bit] = 1'b0;
        node_next.tag[tel_visited_bit] = 1'b0;
        if (use_tel) node_next.tel = cur_q;
        else         node_next.hed = cur_q;
        next_addr = field;
      end
      default: next_addr = back_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      back_q     <= nil_addr;
      cur_q      <= nil_addr;
      tel_pend_q <= 1'b0;
    end else if (start) begin
      back_q     <= nil_addr;
      cur_q      <= start_addr;
      tel_pend_q <= 1'b0;
    end else if (step) begin
      case (action)
        act_push: begin
          back_q     <= cur_q;
          cur_q      <= field;
          tel_pend_q <= 1'b0;
        end
        act_switch: begin
          back_q     <= node.hed;
          cur_q      <= back_q;
          tel_pend_q <= 1'b1;
        end
        act_pop: begin
          back_q <= field;
          cur_q  <= back_q;
        end
        default: ;
      endcase
    end
  end

  // The node being popped is always reached through a live back pointer
  a_pop_has_parent: assert property (@(posedge clk) disable iff (!rst)
    step && action == act_pop |-> back_q != nil_addr);

endmodule

`default_nettype wire

// ==== src/traversal_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module traversal_engine
  import cell_pkg::*;
  import walk_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  start,
  input  wire logic [addr_width-1:0] start_addr,
  output logic                       busy,
  output logic                       done,
  output logic [addr_width-1:0]      cell_count,
  output mem_req_t                   mem_req,
  input  wire cell_word_t            mem_rdata,
  input  wire logic                  mem_ready,
  output logic                       step,
  output cell_word_t                 node,
  input  wire rev_action_e           action,
  input  wire cell_word_t            node_next,
  input  wire logic [addr_width-1:0] next_addr
);

  walk_func_e            state_q;
  logic                  busy_q;
  logic                  done_q;
  logic [addr_width-1:0] count_q;
  logic [addr_width-1:0] cur_addr_q;
  logic [addr_width-1:0] nxt_addr_q;
  cell_word_t            node_q;
  mem_req_t              req_q;
  logic                  read_due;
  logic [addr_width-1:0] due_addr;

  assign step = busy_q && state_q == func_traverse;

  // A read falls due after a leaf, or once a write-back completes
  assign read_due = (step && action == act_leaf) ||
                    (busy_q && state_q == func_write && req_q.valid && mem_ready);
  assign due_addr = (state_q == func_traverse) ? next_addr : nxt_addr_q;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q    <= func_read;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      count_q    <= '0;
      cur_addr_q <= '0;
      nxt_addr_q <= '0;
      node_q     <= '0;
      req_q      <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (start) begin
          busy_q     <= 1'b1;
          count_q    <= addr_width'(1);
          cur_addr_q <= start_addr;
          state_q    <= func_read;
        end
      end else begin
        case (state_q)
          func_read: begin
            if (!req_q.valid) begin
              req_q.valid <= 1'b1;
              req_q.op    <= get_contents;
              req_q.addr  <= cur_addr_q;
            end else if (mem_ready) begin
              node_q      <= mem_rdata;
              req_q.valid <= 1'b0;
              state_q     <= func_traverse;
            end
          end
          func_write: begin
            if (!req_q.valid) begin
              req_q.valid <= 1'b1;
              req_q.op    <= set_contents;
              req_q.addr  <= cur_addr_q;
              req_q.wdata <= node_q;
            end else if (mem_ready) begin
              req_q.valid <= 1'b0;
            end
          end
          func_traverse: begin
            case (action)
              act_push, act_pop: begin
                node_q     <= node_next;
                nxt_addr_q <= next_addr;
                state_q    <= func_write;
                if (action == act_push) count_q <= count_q + 1'b1;
              end
              // Head restored, tail push follows on the next step
              act_switch: node_q <= node_next;
              default: ;
            endcase
          end
          default: state_q <= func_read;
        endcase

        if (read_due) begin
          state_q <= func_read;
          if (due_addr == nil_addr) begin
            // Climbed past the root
            done_q <= 1'b1;
            busy_q <= 1'b0;
          end else begin
            cur_addr_q <= due_addr;
          end
        end
      end
    end
  end

  assign busy       = busy_q;
  assign done       = done_q;
  assign cell_count = count_q;
  assign mem_req    = req_q;
  assign node       = node_q;

endmodule

`default_nettype wire

// ==== src/mem_traversal_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_traversal_top
  import cell_pkg::*;
  import walk_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  start,
  input  wire logic [addr_width-1:0] start_addr,
  output logic                       busy,
  output logic                       done,
  output logic [addr_width-1:0]      cell_count,
  input  wire mem_req_t              host_req,
  output cell_word_t                 host_rdata,
  output logic                       host_ready
);

  mem_req_t              walk_req;
  cell_word_t            walk_rdata;
  logic                  walk_ready;
  logic                  step;
  cell_word_t            node;
  rev_action_e           action;
  cell_word_t            node_next;
  logic [addr_width-1:0] next_addr;
  logic                  start_accept;

  // Pointer registers only reload on a start the engine takes
  assign start_accept = start && !busy;

  traversal_engine engine_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .start_addr (start_addr),
    .busy       (busy),
    .done       (done),
    .cell_count (cell_count),
    .mem_req    (walk_req),
    .mem_rdata  (walk_rdata),
    .mem_ready  (walk_ready),
    .step       (step),
    .node       (node),
    .action     (action),
    .node_next  (node_next),
    .next_addr  (next_addr)
  );

  pointer_reversal rev_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start_accept),
    .start_addr (start_addr),
    .step       (step),
    .node       (node),
    .action     (action),
    .node_next  (node_next),
    .next_addr  (next_addr)
  );

  cell_store store_i (
    .clk        (clk),
    .rst        (rst),
    .walk_req   (walk_req),
    .walk_rdata (walk_rdata),
    .walk_ready (walk_ready),
    .host_req   (host_req),
    .host_rdata (host_rdata),
    .host_ready (host_ready)
  );

endmodule

`default_nettype wire

// ==== tb/mem_traversal_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_traversal_tb
  import cell_pkg::*;
  import walk_pkg::*;
;

  // Run limit well above the longest test sequence
  localparam int timeout_cycles = 20000;
  localparam int max_cells      = 32;

  logic                  clk;
  logic                  rst;
  logic                  start;
  logic [addr_width-1:0] start_addr;
  logic                  busy;
  logic                  done;
  logic [addr_width-1:0] cell_count;
  mem_req_t              host_req;
  cell_word_t            host_rdata;
  logic                  host_ready;

  logic [31:0]           rand_state;
  int                    errors = 0;
  int                    checks = 0;
  int                    cycles = 0;
  cell_word_t            shadow [mem_depth];
  logic [addr_width-1:0] tree_addr [max_cells];
  int                    tree_n;

  mem_traversal_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .start_addr (start_addr),
    .busy       (busy),
    .done       (done),
    .cell_count (cell_count),
    .host_req   (host_req),
    .host_rdata (host_rdata),
    .host_ready (host_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // Linear congruential generator returning 15 bits per call
  function automatic int next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return int'(rand_state[30:16]);
  endfunction

  function automatic cell_word_t random_word();
    cell_word_t w;
    w.tag = 8'(next_rand());
    w.hed = 10'(next_rand());
    w.tel = 10'(next_rand());
    return w;
  endfunction

  // Leaf with random atoms and clear visited marks
  function automatic cell_word_t leaf_word();
    cell_word_t w;
    w.tag = {4'(next_rand()), 4'b0000};
    w.hed = 10'(next_rand());
    w.tel = 10'(next_rand());
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic host_write(input logic [addr_width-1:0] addr, input cell_word_t word);
    @(posedge clk);
    host_req.valid <= 1'b1;
    host_req.op    <= set_contents;
    host_req.addr  <= addr;
    host_req.wdata <= word;
    @(posedge clk);
    while (!host_ready) @(posedge clk);
    host_req.valid <= 1'b0;
  endtask

  task automatic host_read(input logic [addr_width-1:0] addr, output cell_word_t word);
    @(posedge clk);
    host_req.valid <= 1'b1;
    host_req.op    <= get_contents;
    host_req.addr  <= addr;
    @(posedge clk);
    while (!host_ready) @(posedge clk);
    word = host_rdata;
    host_req.valid <= 1'b0;
  endtask

  // Counts distinct cells reachable from the root in the shadow copy
  function automatic int model_count(input logic [addr_width-1:0] root);
    logic [addr_width-1:0] stack [$];
    logic                  seen [mem_depth];
    logic [addr_width-1:0] a;
    cell_word_t            w;
    int                    n;
    n = 0;
    foreach (seen[i]) seen[i] = 1'b0;
    stack.push_back(root);
    while (stack.size() > 0) begin
      a = stack.pop_back();
      if (!seen[a]) begin
        seen[a] = 1'b1;
        n++;
        w = shadow[a];
        if (w.tag[1]) stack.push_back(w.hed);
        if (w.tag[0]) stack.push_back(w.tel);
      end
    end
    return n;
  endfunction

  task automatic load_tree();
    for (int i = 0; i < tree_n; i++) begin
      host_write(tree_addr[i], shadow[tree_addr[i]]);
    end
  endtask

  task automatic verify_tree(input string name);
    cell_word_t got;
    for (int i = 0; i < tree_n; i++) begin
      host_read(tree_addr[i], got);
      check_value($sformatf("%s word %0d", name, i), 32'(shadow[tree_addr[i]]), 32'(got));
    end
  endtask

  task automatic run_walk(input string name, input logic [addr_width-1:0] root,
                          output int count);
    @(posedge clk);
    start      <= 1'b1;
    start_addr <= root;
    @(posedge clk);
    start <= 1'b0;
    while (!done) @(posedge clk);
    count = int'(cell_count);
    check_value({name, " busy at done"}, 32'(0), 32'(busy));
  endtask

  // Three cell_cell nodes over four leaves in heap order
  task automatic build_full_tree();
    cell_word_t w;
    tree_n = 7;
    for (int i = 0; i < 7; i++) tree_addr[i] = addr_width'(100 + 3 * i);
    for (int i = 0; i < 7; i++) begin
      w = leaf_word();
      if (i < 3) begin
        w.tag[1:0] = cell_cell;
        w.hed      = tree_addr[2 * i + 1];
        w.tel      = tree_addr[2 * i + 2];
      end
      shadow[tree_addr[i]] = w;
    end
  endtask

  // Each new cell hangs off a free side of an earlier one
  task automatic build_random_tree();
    cell_word_t w;
    int         base;
    int         slot;
    int         p;
    logic       placed;
    base   = next_rand() % 1000;
    tree_n = 1 + next_rand() % 20;
    for (int i = 0; i < tree_n; i++) begin
      tree_addr[i]         = addr_width'((base + 7 * i) % 1000);
      shadow[tree_addr[i]] = leaf_word();
    end
    for (int i = 1; i < tree_n; i++) begin
      placed = 1'b0;
      slot   = next_rand() % (2 * i);
      while (!placed) begin
        p = slot / 2;
        w = shadow[tree_addr[p]];
        if (slot % 2 == 0 && !w.tag[1]) begin
          w.tag[1] = 1'b1;
          w.hed    = tree_addr[i];
          placed   = 1'b1;
        end else if (slot % 2 == 1 && !w.tag[0]) begin
          w.tag[0] = 1'b1;
          w.tel    = tree_addr[i];
          placed   = 1'b1;
        end
        shadow[tree_addr[p]] = w;
        slot = (slot + 1) % (2 * i);
      end
    end
  endtask

  task automatic test_reset();
    @(posedge clk);
    check_value("reset busy", 32'(0), 32'(busy));
    check_value("reset done", 32'(0), 32'(done));
    check_value("reset cell_count", 32'(0), 32'(cell_count));
    check_value("reset host_ready", 32'(0), 32'(host_ready));
  endtask

  task automatic test_host_port();
    logic [addr_width-1:0] addrs [4];
    cell_word_t            words [4];
    cell_word_t            got;
    addrs = '{10'd5, 10'd300, 10'd777, 10'd1000};
    for (int i = 0; i < 4; i++) begin
      words[i] = random_word();
      host_write(addrs[i], words[i]);
    end
    for (int i = 0; i < 4; i++) begin
      host_read(addrs[i], got);
      check_value($sformatf("host port addr %0d", addrs[i]), 32'(words[i]), 32'(got));
    end
  endtask

  task automatic test_single_root();
    int count;
    tree_n               = 1;
    tree_addr[0]         = 10'd42;
    shadow[tree_addr[0]] = leaf_word();
    load_tree();
    run_walk("single root", tree_addr[0], count);
    check_value("single root count", 32'(1), 32'(count));
    verify_tree("single root");
  endtask

  task automatic test_full_tree();
    int count;
    build_full_tree();
    load_tree();
    run_walk("full tree", tree_addr[0], count);
    check_value("full tree count", 32'(7), 32'(count));
    verify_tree("full tree");
  endtask

  task automatic test_random_tree();
    int count;
    build_random_tree();
    load_tree();
    run_walk("random tree", tree_addr[0], count);
    check_value("random tree count", 32'(model_count(tree_addr[0])), 32'(count));
    verify_tree("random tree");
  endtask

  task automatic test_repeat_walk();
    int first;
    int second;
    build_random_tree();
    load_tree();
    run_walk("repeat walk 1", tree_addr[0], first);
    verify_tree("repeat walk 1");
    run_walk("repeat walk 2", tree_addr[0], second);
    check_value("repeat walk count", 32'(model_count(tree_addr[0])), 32'(first));
    check_value("repeat walk same count", 32'(first), 32'(second));
    verify_tree("repeat walk 2");
  endtask

  initial begin
    rand_state = 32'd58249;
    rst        = 1'b0;
    start      = 1'b0;
    start_addr = '0;
    host_req   = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    test_reset();
    test_host_port();
    test_single_root();
    test_full_tree();
    test_random_tree();
    test_repeat_walk();
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
src/cell_pkg.sv
src/walk_pkg.sv
src/cell_store.sv
src/pointer_reversal.sv
src/traversal_engine.sv
src/mem_traversal_top.sv
tb/mem_traversal_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = mem_traversal_tb
RTL_TOP    = mem_traversal_top
FLIST      = flist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
